//--- verilog.f
+incdir+testbench
common/tcdm_pkg.sv
prio_arbiter/prio_arbiter.sv
rtl/tcdm_bank.sv
rtl/resp_router.sv
rtl/tcdm_subsystem.sv
testbench/tb_tcdm_subsystem.sv

//--- Bender.yml
package:
  name: tcdm_subsystem

sources:
  - common/tcdm_pkg.sv
  - prio_arbiter/prio_arbiter.sv
  - rtl/tcdm_bank.sv
  - rtl/resp_router.sv
  - rtl/tcdm_subsystem.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_tcdm_subsystem.sv

//--- testbench/tb_vectors.svh
/*
 * TCDM subsystem test vectors
 * One row per cycle with control, both request sides and the
 * expected grant vectors, derived from the arbitration rule
 */

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

  // Columns: name, hi req, hi we, lo req, lo we, word address,
  // forced byte enables, expected hi gnt, expected lo gnt
  task automatic load_vectors();
    // ----------------------------------------------------------
    // Default priority, no stall limit
    // ----------------------------------------------------------
    set_ctrl(1'b0, ARB_MODE_BOTH, 8'd0);
    add_row("dflt_coll", 4'b1111, 4'b1111, 4'b0110, 4'b0000, 8'h10, 4'hf, 4'b1111, 4'b0000);
    add_row("dflt_one",  4'b0011, 4'b0000, 4'b1100, 4'b0000, 8'h10, 4'hf, 4'b0011, 4'b1100);
    add_row("lo_only",   4'b0000, 4'b0000, 4'b1111, 4'b1111, 8'h20, 4'hf, 4'b0000, 4'b1111);

    // Low side preferred
    set_ctrl(1'b1, ARB_MODE_BOTH, 8'd0);
    add_row("inv_coll",  4'b1111, 4'b0000, 4'b1010, 4'b0000, 8'h20, 4'hf, 4'b0101, 4'b1010);
    add_row("inv_full",  4'b1111, 4'b1111, 4'b1111, 4'b1111, 8'h30, 4'hf, 4'b0000, 4'b1111);

    // ----------------------------------------------------------
    // Mode 0 starvation limit of 3
    // ----------------------------------------------------------
    set_ctrl(1'b0, ARB_MODE_BOTH, 8'd3);
    add_row("gap_stall", 4'b0000, 4'b0000, 4'b0000, 4'b0000, 8'h00, 4'h0, 4'b0000, 4'b0000);
    add_row("stall_c1",  4'b1111, 4'b1111, 4'b1111, 4'b0000, 8'h40, 4'hf, 4'b1111, 4'b0000);
    add_row("stall_c2",  4'b1111, 4'b1111, 4'b1111, 4'b0000, 8'h40, 4'hf, 4'b1111, 4'b0000);
    add_row("stall_c3",  4'b1111, 4'b1111, 4'b1111, 4'b0000, 8'h40, 4'hf, 4'b1111, 4'b0000);
    // Count at 3, low side takes every bank once
    add_row("stall_c4",  4'b1111, 4'b1111, 4'b1111, 4'b0000, 8'h40, 4'hf, 4'b0000, 4'b1111);
    add_row("stall_c5",  4'b1111, 4'b1111, 4'b1111, 4'b0000, 8'h40, 4'hf, 4'b1111, 4'b0000);

    // ----------------------------------------------------------
    // Mode 1, conflict on bank 1 only, clear in second cycle
    // ----------------------------------------------------------
    set_ctrl(1'b0, ARB_MODE_CONFLICT, 8'd3);
    add_row("gap_conf",  4'b0000, 4'b0000, 4'b0000, 4'b0000, 8'h00, 4'h0, 4'b0000, 4'b0000);
    add_row("conf_c1",   4'b0011, 4'b0000, 4'b0110, 4'b0000, 8'h10, 4'hf, 4'b0011, 4'b0100);
    clear_next();
    add_row("conf_clr",  4'b0011, 4'b0000, 4'b0110, 4'b0000, 8'h10, 4'hf, 4'b0011, 4'b0100);
    add_row("conf_c2",   4'b0011, 4'b0000, 4'b0110, 4'b0000, 8'h10, 4'hf, 4'b0011, 4'b0100);
    add_row("conf_c3",   4'b0011, 4'b0000, 4'b0110, 4'b0000, 8'h10, 4'hf, 4'b0011, 4'b0100);
    add_row("conf_c4",   4'b0011, 4'b0000, 4'b0110, 4'b0000, 8'h10, 4'hf, 4'b0011, 4'b0100);
    add_row("conf_frc",  4'b0011, 4'b0000, 4'b0110, 4'b0000, 8'h10, 4'hf, 4'b0000, 4'b0110);

    // Mode 2, conflict on bank 0 only
    set_ctrl(1'b0, ARB_MODE_SWAP, 8'd3);
    add_row("gap_swap",  4'b0000, 4'b0000, 4'b0000, 4'b0000, 8'h00, 4'h0, 4'b0000, 4'b0000);
    add_row("swap_c1",   4'b1001, 4'b0000, 4'b0011, 4'b0000, 8'h20, 4'hf, 4'b1001, 4'b0010);
    add_row("swap_c2",   4'b1001, 4'b0000, 4'b0011, 4'b0000, 8'h20, 4'hf, 4'b1001, 4'b0010);
    add_row("swap_c3",   4'b1001, 4'b0000, 4'b0011, 4'b0000, 8'h20, 4'hf, 4'b1001, 4'b0010);
    add_row("swap_frc",  4'b1001, 4'b0000, 4'b0011, 4'b0000, 8'h20, 4'hf, 4'b0000, 4'b0011);

    // ----------------------------------------------------------
    // Data path, random data and byte enables
    // ----------------------------------------------------------
    set_ctrl(1'b0, ARB_MODE_BOTH, 8'd0);
    add_row("gap_data",  4'b0000, 4'b0000, 4'b0000, 4'b0000, 8'h00, 4'h0, 4'b0000, 4'b0000);
    add_row("wr_hi",     4'b1111, 4'b1111, 4'b0000, 4'b0000, 8'h10, 4'h0, 4'b1111, 4'b0000);
    add_row("rd_lo",     4'b0000, 4'b0000, 4'b1111, 4'b0000, 8'h10, 4'h0, 4'b0000, 4'b1111);
    add_row("wr_lo",     4'b0000, 4'b0000, 4'b1111, 4'b1111, 8'h20, 4'h0, 4'b0000, 4'b1111);
    add_row("rd_mix",    4'b0101, 4'b0000, 4'b1010, 4'b0000, 8'h20, 4'h0, 4'b0101, 4'b1010);
    add_row("rd_block",  4'b1111, 4'b0000, 4'b1111, 4'b1111, 8'h20, 4'hf, 4'b1111, 4'b0000);
    set_ctrl(1'b1, ARB_MODE_BOTH, 8'd0);
    add_row("wr_inv",    4'b1111, 4'b1111, 4'b0011, 4'b0011, 8'h30, 4'h0, 4'b1100, 4'b0011);
    add_row("rd_inv",    4'b1111, 4'b0000, 4'b0000, 4'b0000, 8'h30, 4'h0, 4'b1111, 4'b0000);
  endtask

`endif

//--- testbench/tb_tcdm_subsystem.sv
/*
 * TCDM subsystem testbench
 * Applies the vector table one row per cycle, checks grants in the
 * same cycle and responses one cycle later against a shadow memory
 */

`timescale 1ns/1ps

module tb_tcdm_subsystem
  import tcdm_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 16;
  localparam int RST_TIMEOUT = 100;  // Cycles allowed for reset release

  typedef struct packed {
    logic               clr;
    arb_ctrl_t          ctrl;
    logic [NB_CHAN-1:0] hi_req;
    logic [NB_CHAN-1:0] hi_we;
    logic [NB_CHAN-1:0] lo_req;
    logic [NB_CHAN-1:0] lo_we;
    logic [ADDR_W-1:0]  add;
    logic [BE_W-1:0]    be;      // Forced enables OR random bits
    logic [NB_CHAN-1:0] exp_hi;
    logic [NB_CHAN-1:0] exp_lo;
  } vec_row_t;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    clear_i;
  arb_ctrl_t               ctrl_i;
  tcdm_req_t [NB_CHAN-1:0] hi_req_i;
  tcdm_req_t [NB_CHAN-1:0] lo_req_i;
  tcdm_rsp_t [NB_CHAN-1:0] hi_rsp_o;
  tcdm_rsp_t [NB_CHAN-1:0] lo_rsp_o;

  vec_row_t           rows[$];
  string              row_names[$];
  arb_ctrl_t          cur_ctrl;
  logic               cur_clr;
  logic [31:0]        lcg_state = 32'd54119;
  logic [DATA_W-1:0]  shadow [NB_CHAN][2**ADDR_W];  // Expected bank contents
  logic [NB_CHAN-1:0] exp_hv;  // High r_valid due next cycle
  logic [NB_CHAN-1:0] exp_lv;  // Low r_valid due next cycle
  logic [NB_CHAN-1:0] rd_chk;  // Read data to check
  logic [NB_CHAN-1:0] rd_hi;   // Read owned by the high side
  logic [DATA_W-1:0]  exp_rdata [NB_CHAN];
  int                 test_errs = 0;
  int                 n_pass = 0;
  int                 n_fail = 0;

  tcdm_subsystem DUT (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .clear_i  ( clear_i  ),
    .ctrl_i   ( ctrl_i   ),
    .hi_req_i ( hi_req_i ),
    .lo_req_i ( lo_req_i ),
    .hi_rsp_o ( hi_rsp_o ),
    .lo_rsp_o ( lo_rsp_o )
  );

  initial
  begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  initial
  begin : reset_gen
    rst_ni = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
  end

  // ----------------------------------------------------------
  // Table building and stimulus
  // ----------------------------------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic set_ctrl(input logic inv, input logic [1:0] mode,
                          input logic [STALL_W-1:0] stall);
    cur_ctrl = '{invert_prio: inv, mode: mode, max_stall: stall};
  endtask

  task automatic clear_next();
    cur_clr = 1'b1;  // Only the next row
  endtask

  task automatic add_row(input string name, input logic [3:0] hr, input logic [3:0] hw,
                         input logic [3:0] lr, input logic [3:0] lw,
                         input logic [7:0] add, input logic [3:0] be,
                         input logic [3:0] eh, input logic [3:0] el);
    rows.push_back('{clr: cur_clr, ctrl: cur_ctrl, hi_req: hr, hi_we: hw, lo_req: lr,
                     lo_we: lw, add: add, be: be, exp_hi: eh, exp_lo: el});
    row_names.push_back(name);
    cur_clr = 1'b0;
  endtask

  `include "tb_vectors.svh"

  task automatic drive_row(input vec_row_t row);
    logic [31:0] rnd;
    clear_i = row.clr;
    ctrl_i  = row.ctrl;
    for (int i = 0; i < NB_CHAN; i++)
    begin
      rnd = lcg_next();
      hi_req_i[i] = '{req: row.hi_req[i], we: row.hi_we[i], be: row.be | rnd[16 +: BE_W],
                      add: row.add, data: lcg_next()};
      rnd = lcg_next();
      lo_req_i[i] = '{req: row.lo_req[i], we: row.lo_we[i], be: row.be | rnd[16 +: BE_W],
                      add: row.add, data: lcg_next()};
    end
  endtask

  // ----------------------------------------------------------
  // Reference model and checks
  // ----------------------------------------------------------

  // Owner taken from the expected grants and shadow updated after the read
  task automatic update_model(input vec_row_t row);
    tcdm_req_t req;
    for (int i = 0; i < NB_CHAN; i++)
    begin
      exp_hv[i] = row.exp_hi[i] && !row.clr;  // Clear kills next pulse
      exp_lv[i] = row.exp_lo[i] && !row.clr;
      rd_hi[i]  = row.exp_hi[i];
      rd_chk[i] = 1'b0;
      req       = row.exp_hi[i] ? hi_req_i[i] : lo_req_i[i];
      if (row.exp_hi[i] || row.exp_lo[i])
      begin
        if (!req.we)
        begin
          rd_chk[i]    = !row.clr;
          exp_rdata[i] = shadow[i][req.add];  // Word before this edge
        end
        else
        begin
          for (int b = 0; b < BE_W; b++)
          begin
            if (req.be[b])
            begin
              shadow[i][req.add][b*8 +: 8] = req.data[b*8 +: 8];
            end
          end
        end
      end
    end
  endtask

  task automatic check_val(input string name, input string what,
                           input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
    if (act !== exp)
    begin
      $display("Fail %s: %s expected %h actual %h", name, what, exp, act);
      test_errs++;
    end
  endtask

  function automatic logic [NB_CHAN-1:0] gnt_bits(input tcdm_rsp_t [NB_CHAN-1:0] rsp);
    logic [NB_CHAN-1:0] v;
    for (int i = 0; i < NB_CHAN; i++)
    begin
      v[i] = rsp[i].gnt;
    end
    return v;
  endfunction

  function automatic logic [NB_CHAN-1:0] rvalid_bits(input tcdm_rsp_t [NB_CHAN-1:0] rsp);
    logic [NB_CHAN-1:0] v;
    for (int i = 0; i < NB_CHAN; i++)
    begin
      v[i] = rsp[i].r_valid;
    end
    return v;
  endfunction

  task automatic check_rsp(input string name);
    logic [DATA_W-1:0] act;
    check_val(name, "hi r_valid", exp_hv, rvalid_bits(hi_rsp_o));
    check_val(name, "lo r_valid", exp_lv, rvalid_bits(lo_rsp_o));
    for (int i = 0; i < NB_CHAN; i++)
    begin
      if (rd_chk[i])
      begin
        act = rd_hi[i] ? hi_rsp_o[i].r_data : lo_rsp_o[i].r_data;
        check_val(name, $sformatf("bank %0d r_data", i), exp_rdata[i], act);
      end
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0)
    begin
      n_pass++;
      $display("ok   %s", name);
    end
    else
    begin
      n_fail++;
      $display("bad  %s (%0d mismatches)", name, test_errs);
    end
    test_errs = 0;
  endtask

  // Row r drives at the falling edge where row r-1 responses are due
  task automatic run_table();
    vec_row_t row;
    string    prev_name;
    prev_name = "";
    for (int r = 0; r < rows.size(); r++)
    begin
      @(negedge clk_i);
      if (r > 0)
      begin
        check_rsp(prev_name);
        finish_test(prev_name);
      end
      row = rows[r];
      drive_row(row);
      #(CLK_PERIOD/4);  // gnt settled before the rising edge
      check_val(row_names[r], "hi gnt", row.exp_hi, gnt_bits(hi_rsp_o));
      check_val(row_names[r], "lo gnt", row.exp_lo, gnt_bits(lo_rsp_o));
      update_model(row);
      prev_name = row_names[r];
    end
    @(negedge clk_i);
    check_rsp(prev_name);
    finish_test(prev_name);
    clear_i  = 1'b0;
    hi_req_i = '0;
    lo_req_i = '0;
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial
  begin : stimulus
    int wait_cnt;
    clear_i  = 1'b0;
    ctrl_i   = '0;
    hi_req_i = '0;
    lo_req_i = '0;
    cur_clr  = 1'b0;
    cur_ctrl = '0;
    load_vectors();
    wait_cnt = 0;
    while (rst_ni !== 1'b1 && wait_cnt < RST_TIMEOUT)
    begin
      @(posedge clk_i);
      wait_cnt++;
    end
    if (rst_ni !== 1'b1)
    begin
      $display("Timeout: reset was not released within %0d cycles", RST_TIMEOUT);
      $display("sim failed");
    end
    else
    begin
      @(negedge clk_i);
      check_val("reset_state", "hi gnt", '0, gnt_bits(hi_rsp_o));
      check_val("reset_state", "lo gnt", '0, gnt_bits(lo_rsp_o));
      check_val("reset_state", "hi r_valid", '0, rvalid_bits(hi_rsp_o));
      check_val("reset_state", "lo r_valid", '0, rvalid_bits(lo_rsp_o));
      finish_test("reset_state");
      run_table();
      $display("Summary: %0d tests passed, %0d tests failed", n_pass, n_fail);
      if (n_fail == 0)
      begin
        $display("sim passed");
      end
      else
      begin
        $display("sim failed");
      end
    end
    $finish;
  end

endmodule : tb_tcdm_subsystem

//--- rtl/tcdm_subsystem.sv
/*
 * TCDM subsystem top level
 * NB_CHAN banks shared by a high and a low priority initiator side,
 * channel i of each side reaching bank i through the arbiter
 */

`timescale 1ns/1ps

module tcdm_subsystem
  import tcdm_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  arb_ctrl_t               ctrl_i,
  input  tcdm_req_t [NB_CHAN-1:0] hi_req_i,
  input  tcdm_req_t [NB_CHAN-1:0] lo_req_i,
  output tcdm_rsp_t [NB_CHAN-1:0] hi_rsp_o,
  output tcdm_rsp_t [NB_CHAN-1:0] lo_rsp_o
);

  tcdm_req_t [NB_CHAN-1:0]             bank_req;    // Arbiter to banks
  logic      [NB_CHAN-1:0]             grant_hi;    // Owner per bank
  logic      [NB_CHAN-1:0]             hi_gnt;
  logic      [NB_CHAN-1:0]             lo_gnt;
  logic      [NB_CHAN-1:0][DATA_W-1:0] bank_rdata;  // Banks to router
  logic      [NB_CHAN-1:0]             hi_rvalid;
  logic      [NB_CHAN-1:0]             lo_rvalid;
  logic      [NB_CHAN-1:0][DATA_W-1:0] hi_rdata;
  logic      [NB_CHAN-1:0][DATA_W-1:0] lo_rdata;

  // ----------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------

  prio_arbiter i_arbiter (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .clear_i    ( clear_i  ),
    .ctrl_i     ( ctrl_i   ),
    .hi_req_i   ( hi_req_i ),
    .lo_req_i   ( lo_req_i ),
    .bank_req_o ( bank_req ),
    .grant_hi_o ( grant_hi ),
    .hi_gnt_o   ( hi_gnt   ),
    .lo_gnt_o   ( lo_gnt   )
  );

  // ----------------------------------------------------------
  // Memory banks
  // ----------------------------------------------------------

  for (genvar i = 0; i < NB_CHAN; i++)
  begin : gen_bank
    tcdm_bank i_bank (
      .clk_i   ( clk_i         ),
      .rst_ni  ( rst_ni        ),
      .req_i   ( bank_req[i]   ),
      .rdata_o ( bank_rdata[i] )
    );
  end

  // ----------------------------------------------------------
  // Response path
  // ----------------------------------------------------------

  resp_router i_router (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .bank_req_i   ( bank_req   ),
    .grant_hi_i   ( grant_hi   ),
    .bank_rdata_i ( bank_rdata ),
    .hi_rvalid_o  ( hi_rvalid  ),
    .lo_rvalid_o  ( lo_rvalid  ),
    .hi_rdata_o   ( hi_rdata   ),
    .lo_rdata_o   ( lo_rdata   )
  );

  // gnt from the arbiter, r_valid and r_data from the router
  for (genvar i = 0; i < NB_CHAN; i++)
  begin : gen_rsp
    assign hi_rsp_o[i] = '{gnt: hi_gnt[i], r_valid: hi_rvalid[i], r_data: hi_rdata[i]};
    assign lo_rsp_o[i] = '{gnt: lo_gnt[i], r_valid: lo_rvalid[i], r_data: lo_rdata[i]};
  end

endmodule : tcdm_subsystem

//--- rtl/resp_router.sv
/*
 * Response router
 * Tracks the owning side of each bank access and returns the
 * one-cycle r_valid pulse to that side only
 */

`timescale 1ns/1ps

module resp_router
  import tcdm_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clear_i,
  input  tcdm_req_t [NB_CHAN-1:0]        bank_req_i,
  input  logic      [NB_CHAN-1:0]        grant_hi_i,
  input  logic      [NB_CHAN-1:0][DATA_W-1:0] bank_rdata_i,
  output logic      [NB_CHAN-1:0]        hi_rvalid_o,
  output logic      [NB_CHAN-1:0]        lo_rvalid_o,
  output logic      [NB_CHAN-1:0][DATA_W-1:0] hi_rdata_o,
  output logic      [NB_CHAN-1:0][DATA_W-1:0] lo_rdata_o
);

  logic [NB_CHAN-1:0] accepted;  // Bank took a request this cycle
  logic [NB_CHAN-1:0] valid_q;   // Response due this cycle
  logic [NB_CHAN-1:0] hi_own_q;  // 1 = high side owns that response

  always_comb
  begin
    for (int i = 0; i < NB_CHAN; i++)
    begin
      accepted[i] = bank_req_i[i].req;
    end
  end

  // ----------------------------------------------------------
  // Pending response state
  // ----------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q  <= '0;
      hi_own_q <= '0;
    end
    else
    begin
      valid_q  <= clear_i ? '0 : accepted;  // Clear drops pending pulses
      hi_own_q <= grant_hi_i;
    end
  end

  // Pulse goes to the owner only
  assign hi_rvalid_o = valid_q & hi_own_q;
  assign lo_rvalid_o = valid_q & ~hi_own_q;

  // Bank word shown on both sides, r_valid qualifies it
  assign hi_rdata_o = bank_rdata_i;
  assign lo_rdata_o = bank_rdata_i;

endmodule : resp_router

//--- rtl/tcdm_bank.sv
/*
 * TCDM bank
 * Single-port synchronous word SRAM model with byte enables
 * and one cycle of read latency, accepts a request every cycle
 */

`timescale 1ns/1ps

module tcdm_bank
  import tcdm_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  tcdm_req_t         req_i,
  output logic [DATA_W-1:0] rdata_o
);

  localparam int unsigned DEPTH = 2**ADDR_W;

  logic [DATA_W-1:0] mem_q [DEPTH];  // Contents undefined after reset
  logic              wr_en;

  assign wr_en = req_i.req && req_i.we;

  // ----------------------------------------------------------
  // Write port
  // ----------------------------------------------------------

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      for (int b = 0; b < BE_W; b++)
      begin
        if (req_i.be[b])
        begin
          mem_q[req_i.add][b*8 +: 8] <= req_i.data[b*8 +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Read register
  // ----------------------------------------------------------

  // Registered on every request, so a write also returns the old word
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rdata_o <= '0;
    end
    else if (req_i.req)
    begin
      rdata_o <= mem_q[req_i.add];  // Value before the same-edge write
    end
  end

endmodule : tcdm_bank

//--- prio_arbiter/prio_arbiter.sv
/*
 * Unbalanced-priority bank arbiter
 * Picks the high or low initiator side for every bank each cycle,
 * with run-time priority swap and a stall counter that lets the
 * other side through once the limit is reached
 */

`timescale 1ns/1ps

module prio_arbiter
  import tcdm_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  arb_ctrl_t                 ctrl_i,
  input  tcdm_req_t [NB_CHAN-1:0]   hi_req_i,
  input  tcdm_req_t [NB_CHAN-1:0]   lo_req_i,
  output tcdm_req_t [NB_CHAN-1:0]   bank_req_o,
  output logic      [NB_CHAN-1:0]   grant_hi_o,
  output logic      [NB_CHAN-1:0]   hi_gnt_o,
  output logic      [NB_CHAN-1:0]   lo_gnt_o
);

  logic [NB_CHAN-1:0] hi_req_vec;   // Physical high side strobes
  logic [NB_CHAN-1:0] lo_req_vec;   // Physical low side strobes
  logic [NB_CHAN-1:0] pref_req;     // H, preferred side strobes
  logic [NB_CHAN-1:0] other_req;    // L, other side strobes
  logic [NB_CHAN-1:0] pref_own;     // Bank goes to preferred side
  logic               force_other;  // Stall limit reached
  logic               pref_active;  // Preferred side holds the banks
  logic               cnt_inc;      // Counter advance condition
  logic [STALL_W-1:0] stall_cnt_q;

  // ----------------------------------------------------------
  // Side mapping
  // ----------------------------------------------------------

  always_comb
  begin
    for (int i = 0; i < NB_CHAN; i++)
    begin
      hi_req_vec[i] = hi_req_i[i].req;
      lo_req_vec[i] = lo_req_i[i].req;
    end
  end

  // invert_prio swaps which physical side is H
  assign pref_req  = ctrl_i.invert_prio ? lo_req_vec : hi_req_vec;
  assign other_req = ctrl_i.invert_prio ? hi_req_vec : lo_req_vec;

  // ----------------------------------------------------------
  // Side selection
  // ----------------------------------------------------------

  // Limit of zero switches the starvation guard off
  assign force_other = (ctrl_i.max_stall != '0) && (stall_cnt_q >= ctrl_i.max_stall);
  assign pref_active = (|pref_req) && !force_other;

  // H keeps its own banks unless forced, every bank flips on a forced cycle
  assign pref_own = pref_req & {NB_CHAN{pref_active}};

  // Back to physical sides
  assign grant_hi_o = ctrl_i.invert_prio ? ~pref_own : pref_own;

  // ----------------------------------------------------------
  // Request mux and grant return
  // ----------------------------------------------------------

  always_comb
  begin
    for (int i = 0; i < NB_CHAN; i++)
    begin
      // Owner's request including its req strobe
      if (grant_hi_o[i])
      begin
        bank_req_o[i] = hi_req_i[i];
      end
      else
      begin
        bank_req_o[i] = lo_req_i[i];
      end
    end
  end

  // Banks never stall so gnt is just the owner's req
  assign hi_gnt_o = hi_req_vec & grant_hi_o;
  assign lo_gnt_o = lo_req_vec & ~grant_hi_o;

  // ----------------------------------------------------------
  // Stall counter
  // ----------------------------------------------------------

  always_comb
  begin
    case (ctrl_i.mode)
      ARB_MODE_BOTH:
      begin
        cnt_inc = pref_active && (|other_req);  // Other side kept waiting
      end
      default:
      begin
        cnt_inc = |(pref_req & other_req);      // Real bank collisions
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      stall_cnt_q <= '0;
    end
    else if (clear_i)
    begin
      stall_cnt_q <= '0;
    end
    else if (cnt_inc)
    begin
      stall_cnt_q <= stall_cnt_q + 1'b1;  // Wraps at 8 bits
    end
    else
    begin
      stall_cnt_q <= '0;
    end
  end

endmodule : prio_arbiter

//--- common/tcdm_pkg.sv
/*
 * TCDM subsystem package
 * Sizes, arbitration mode codes and the request, response and
 * control structs shared by the arbiter, router, banks and top level
 */

package tcdm_pkg;

  // ----------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------

  localparam int unsigned NB_CHAN = 4;         // Banks, also channels per side
  localparam int unsigned ADDR_W  = 8;         // Word address inside one bank
  localparam int unsigned DATA_W  = 32;        // Bank word width
  localparam int unsigned BE_W    = DATA_W/8;  // One enable per byte
  localparam int unsigned STALL_W = 8;         // Stall counter and limit

  // ----------------------------------------------------------
  // Arbitration modes
  // ----------------------------------------------------------

  // Mode 0: counter runs while preferred side active and other side waiting
  localparam logic [1:0] ARB_MODE_BOTH     = 2'd0;
  // Mode 1: counter runs on real per-bank conflicts only
  localparam logic [1:0] ARB_MODE_CONFLICT = 2'd1;
  // Mode 2: conflict counting, forced cycle flips every bank
  localparam logic [1:0] ARB_MODE_SWAP     = 2'd2;

  // ----------------------------------------------------------
  // Channel structs
  // ----------------------------------------------------------

  // Initiator to bank
  typedef struct packed {
    logic              req;   // Request strobe
    logic              we;    // 1 = write, 0 = read
    logic [BE_W-1:0]   be;    // Byte enables, writes only
    logic [ADDR_W-1:0] add;   // Word address
    logic [DATA_W-1:0] data;  // Write data
  } tcdm_req_t;

  // Bank side back to initiator
  typedef struct packed {
    logic              gnt;      // Same cycle as req
    logic              r_valid;  // One cycle after the granted cycle
    logic [DATA_W-1:0] r_data;   // Read word, undefined after a write
  } tcdm_rsp_t;

  // Global arbitration control
  typedef struct packed {
    logic               invert_prio;  // Low side becomes preferred
    logic [1:0]         mode;         // One of the ARB_MODE_* codes
    logic [STALL_W-1:0] max_stall;    // Zero disables the starvation limit
  } arb_ctrl_t;

endpackage : tcdm_pkg
